// File: vlog.f
verilog/mux_link_pkg.sv
verilog/mux_rx_capture.sv
verilog/mux_link_trainer.sv
verilog/mux_tx_framer.sv
verilog/mux_link_top.sv
tb/tb_clk_gen.sv
tb/mux_link_assertions.sv
tb/tb_mux_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mux link testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_mux_link \
	-f vlog.f \
	-o Vtb_mux_link

status=0
sim_out=$(./obj_dir/Vtb_mux_link +verilator+error+limit+100 2>&1) || status=$?
echo "$sim_out"

if grep -qF "TEST RESULT: PASS" <<< "$sim_out"; then
	exit 0
fi

echo "Simulation failed, exit status $status"
exit 1

// File: tb/tb_mux_link.sv
`timescale 1ns/10ps
`default_nettype none

// Loopback testbench for the mux link
module tb_mux_link import mux_link_pkg::*; ();

	logic      GMII_GTX_CLK_int;
	logic      dsp_rst;
	logic      rst_req    = 1'b0;
	mux_word_t raw_word   = '0;
	payload_t  sw         = '0;
	mux_word_t tx_word;
	mux_word_t leds;
	// Cable misalignment and cut
	slip_ofs_t k          = '0;
	logic      break_link = 1'b0;
	integer    seed       = 32'hbc0a;
	integer    rnd;
	int        i;

	tb_clk_gen u_tb_clk_gen (
		.rst_req_i        (rst_req),
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst)
	);

	mux_link_top u_mux_link_top (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.raw_word_i       (raw_word),
		.sw_i             (sw),
		.tx_word_o        (tx_word),
		.leds_o           (leds)
	);

	function automatic mux_word_t rotate_right(input mux_word_t w, input slip_ofs_t n);
		logic [15:0] dbl;
		dbl = {w, w} >> n;
		return dbl[7:0];
	endfunction

	// Own transmit word comes back misaligned by k, or dead while cut
	always @(posedge GMII_GTX_CLK_int) begin
		if (break_link) begin
			raw_word <= '0;
		end else begin
			raw_word <= rotate_right(tx_word, k);
		end
	end

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	// Stop at the first failed link check
	always @(posedge GMII_GTX_CLK_int) begin
		if (u_mux_link_top.u_mux_link_assertions.fail_count != 0) begin
			stop_on_failure("A link check failed, see the message above");
		end
	end

	task automatic wait_reset_release(input int max_cycles);
		int n;
		n = 0;
		while (dsp_rst && n < max_cycles) begin
			@(posedge GMII_GTX_CLK_int);
			n = n + 1;
		end
		if (dsp_rst) begin
			stop_on_failure($sformatf("Timeout at %0t: reset never released", $time));
		end
	endtask

	// Poll the LED synced flag
	task automatic wait_link_flag(input logic level, input int max_cycles, input string what);
		int n;
		n = 0;
		while (leds[MON_BIT] !== level && n < max_cycles) begin
			@(posedge GMII_GTX_CLK_int);
			n = n + 1;
		end
		if (leds[MON_BIT] !== level) begin
			stop_on_failure($sformatf("Timeout at %0t: %s within %0d cycles", $time, what,
				max_cycles));
		end
	endtask

	// Random switch levels while the link has to stay up
	task automatic drive_switches(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(posedge GMII_GTX_CLK_int);
			if (leds[MON_BIT] !== 1'b1) begin
				stop_on_failure($sformatf("error at %0t: link dropped during synced traffic",
					$time));
			end
			rnd = $random(seed);
			sw <= rnd[6:0];
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		// First misalignment while still in reset
		@(posedge GMII_GTX_CLK_int);
		rnd = $random(seed);
		k <= rnd[2:0];
		wait_reset_release(40);

		for (i = 0; i < 4; i++) begin
			wait_link_flag(1'b1, 8 * int'(BITSLIP_HOLDOFF) + 24, "link did not lock");
			drive_switches(40);
			// Cut the cable, re-seat it at another angle
			@(posedge GMII_GTX_CLK_int);
			break_link <= 1'b1;
			wait_link_flag(1'b0, 20, "link did not drop on a cut");
			@(posedge GMII_GTX_CLK_int);
			rnd = $random(seed);
			k <= rnd[2:0];
			repeat (4) @(posedge GMII_GTX_CLK_int);
			break_link <= 1'b0;
		end
		wait_link_flag(1'b1, 8 * int'(BITSLIP_HOLDOFF) + 24, "link did not relock");
		drive_switches(40);

		// Reset in the middle of synced traffic
		@(posedge GMII_GTX_CLK_int);
		rst_req <= 1'b1;
		repeat (3) @(posedge GMII_GTX_CLK_int);
		rst_req <= 1'b0;
		wait_reset_release(20);
		wait_link_flag(1'b1, 8 * int'(BITSLIP_HOLDOFF) + 24, "link did not lock after reset");
		drive_switches(20);

		// Half a cycle on, the checks of the last edge have run
		@(negedge GMII_GTX_CLK_int);
		if (u_mux_link_top.u_mux_link_assertions.fail_count != 0) begin
			stop_on_failure("A link check failed, see the message above");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb/mux_link_assertions.sv
`timescale 1ns/10ps
`default_nettype none

// Link rule checks, bound into the top level
module mux_link_assertions import mux_link_pkg::*; (
	input logic      GMII_GTX_CLK_int,
	input logic      dsp_rst,
	input logic      bitslip_i,
	input logic      synced_i,
	input logic      send_lock_i,
	input payload_t  sw_i,
	input mux_word_t tx_word_i,
	input mux_word_t leds_i
);

	// Failed checks so far
	int fail_count = 0;

	// Cycles since the last slip up to the holdoff
	logic [3:0] slip_gap;

	// Set by the first lock word request after reset
	logic locked_once;

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			slip_gap <= 4'(BITSLIP_HOLDOFF);
		end else if (bitslip_i) begin
			slip_gap <= 4'd1;
		end else if (slip_gap < 4'(BITSLIP_HOLDOFF)) begin
			slip_gap <= slip_gap + 4'd1;
		end
	end

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			locked_once <= 1'b0;
		end else if (send_lock_i) begin
			locked_once <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Reset and training words
	//////////////////////////////////////////////////

	// Idle word out and LEDs dark one cycle after reset
	reset_values: assert property (@(posedge GMII_GTX_CLK_int)
		dsp_rst |=> (tx_word_i == SYNC_IDLE_WORD) && (leds_i == '0))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: tx_word_o or leds_o not cleared by reset", $time);
	end

	// LEDs stay dark until the first lock
	dark_before_lock: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		(!locked_once && !send_lock_i) |=> (leds_i == '0))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: leds_o is %h before the first lock", $time, leds_i);
	end

	// Searching sends the idle word
	idle_word: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		(!synced_i && !send_lock_i) |=> (tx_word_i == SYNC_IDLE_WORD))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: tx_word_o is %h, idle word expected", $time, tx_word_i);
	end

	// Locking sends the lock word
	lock_word: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		(!synced_i && send_lock_i) |=> (tx_word_i == SYNC_LOCK_WORD))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: tx_word_o is %h, lock word expected", $time, tx_word_i);
	end

	// Slips spaced by at least the loop latency
	slip_spacing: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		bitslip_i |-> (slip_gap >= 4'(BITSLIP_HOLDOFF)))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: bitslip only %0d cycles after the last one", $time, slip_gap);
	end

	//////////////////////////////////////////////////
	// Synced traffic
	//////////////////////////////////////////////////

	// LED flag follows synced one cycle later
	led_flag: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		1'b1 |=> (leds_i[MON_BIT] == $past(synced_i)))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: leds_o bit 7 does not follow the link state", $time);
	end

	// Monitor bit flips every cycle once data flows
	mon_toggle: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		(synced_i && $past(synced_i)) |=> (tx_word_i[MON_BIT] != $past(tx_word_i[MON_BIT])))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: monitor bit of tx_word_o did not toggle", $time);
	end

	// Switches go out one cycle later
	tx_payload: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		synced_i |=> (tx_word_i[MON_BIT-1:0] == $past(sw_i)))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: tx_word_o payload %h, sw_i was %h", $time,
			tx_word_i[MON_BIT-1:0], $past(sw_i));
	end

	// Loopback through tb register, capture, trainer and LED register
	loop_payload: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		(synced_i && $past(synced_i) && $past(synced_i, 2))
		|-> (leds_i[MON_BIT-1:0] == $past(tx_word_i[MON_BIT-1:0], 4)))
	else begin
		fail_count = fail_count + 1;
		$error("error at %0t: leds_o payload %h differs from the looped word", $time,
			leds_i[MON_BIT-1:0]);
	end

endmodule

bind mux_link_top mux_link_assertions u_mux_link_assertions (
	.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
	.dsp_rst          (dsp_rst),
	.bitslip_i        (bitslip),
	.synced_i         (synced),
	.send_lock_i      (send_lock),
	.sw_i             (sw_i),
	.tx_word_i        (tx_word_o),
	.leds_i           (leds_o)
);

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Clock and reset source for the mux link testbench
module tb_clk_gen (
	input  logic rst_req_i,
	output logic GMII_GTX_CLK_int,
	output logic dsp_rst
);

	logic       clk = 1'b0;
	logic       rst = 1'b1;
	// Edges seen since time zero, parks at ten
	logic [3:0] por_cnt = '0;

	// 10 ns period
	always #5 clk = ~clk;

	// Power-on reset for ten cycles, later only on request
	always @(posedge clk) begin
		if (por_cnt != 4'd10) begin
			por_cnt <= por_cnt + 4'd1;
		end
		rst <= (por_cnt < 4'd9) || rst_req_i;
	end

	assign GMII_GTX_CLK_int = clk;
	assign dsp_rst          = rst;

endmodule

`default_nettype wire

// File: verilog/mux_link_top.sv
`timescale 1ns/10ps
`default_nettype none

// Mux link: capture -> trainer -> framer
module mux_link_top import mux_link_pkg::*; (
	input  logic      GMII_GTX_CLK_int,
	input  logic      dsp_rst,
	input  mux_word_t raw_word_i,
	input  payload_t  sw_i,
	output mux_word_t tx_word_o,
	output mux_word_t leds_o
);

	//////////////////////////////////////////////////
	// Internal links
	//////////////////////////////////////////////////

	// Aligned receive word
	mux_word_t rx_word;
	// Trainer to capture
	logic      bitslip;
	// Trainer to framer
	logic      synced;
	logic      send_lock;
	payload_t  rx_payload;

	// Receive side, slip model
	mux_rx_capture u_mux_rx_capture (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.raw_word_i       (raw_word_i),
		.bitslip_i        (bitslip),
		.rx_word_o        (rx_word)
	);

	// Alignment and link monitor
	mux_link_trainer u_mux_link_trainer (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.rx_word_i        (rx_word),
		.bitslip_o        (bitslip),
		.synced_o         (synced),
		.send_lock_o      (send_lock),
		.rx_payload_o     (rx_payload)
	);

	// Transmit word and LEDs
	mux_tx_framer u_mux_tx_framer (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.synced_i         (synced),
		.send_lock_i      (send_lock),
		.sw_i             (sw_i),
		.rx_payload_i     (rx_payload),
		.tx_word_o        (tx_word_o),
		.leds_o           (leds_o)
	);

endmodule

`default_nettype wire

// File: verilog/mux_tx_framer.sv
`timescale 1ns/10ps
`default_nettype none

// Outgoing word and LED word
module mux_tx_framer import mux_link_pkg::*; (
	input  logic      GMII_GTX_CLK_int,
	input  logic      dsp_rst,
	input  logic      synced_i,
	input  logic      send_lock_i,
	input  payload_t  sw_i,
	input  payload_t  rx_payload_i,
	output mux_word_t tx_word_o,
	output mux_word_t leds_o
);

	// Toggles every cycle so the far side can spot a dead link
	logic mon_tog;

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			mon_tog <= 1'b0;
		end else begin
			mon_tog <= ~mon_tog;
		end
	end

	//////////////////////////////////////////////////
	// Transmit word
	//////////////////////////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			tx_word_o <= SYNC_IDLE_WORD;
		end else if (synced_i) begin
			// Monitor bit over the switches
			tx_word_o[MON_BIT]     <= mon_tog;
			tx_word_o[MON_BIT-1:0] <= sw_i;
		end else if (send_lock_i) begin
			tx_word_o <= SYNC_LOCK_WORD;
		end else begin
			tx_word_o <= SYNC_IDLE_WORD;
		end
	end

	// LEDs: synced flag in bit 7, far side switches below
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			leds_o <= '0;
		end else begin
			leds_o <= {synced_i, rx_payload_i};
		end
	end

endmodule

`default_nettype wire

// File: verilog/mux_link_trainer.sv
`timescale 1ns/10ps
`default_nettype none

// Link alignment and monitor FSM
module mux_link_trainer import mux_link_pkg::*; (
	input  logic      GMII_GTX_CLK_int,
	input  logic      dsp_rst,
	input  mux_word_t rx_word_i,
	output logic      bitslip_o,
	output logic      synced_o,
	output logic      send_lock_o,
	output payload_t  rx_payload_o
);

	link_state_t state;

	// Slip holdoff, counts down to zero
	logic [2:0] slip_hold;

	// Monitor bit tracking once synced
	logic mon_valid;
	logic mon_expect;

	// Either training word seen on the wire
	logic is_training;

	assign is_training = (rx_word_i == SYNC_IDLE_WORD) || (rx_word_i == SYNC_LOCK_WORD);

	// State register doubles as the synced flag
	assign synced_o = (state == SYNCED);

	//////////////////////////////////////////////////
	// Trainer FSM
	//////////////////////////////////////////////////

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			state       <= SEARCH;
			bitslip_o   <= 1'b0;
			send_lock_o <= 1'b0;
			slip_hold   <= '0;
			mon_valid   <= 1'b0;
			mon_expect  <= 1'b0;
		end else begin
			// Single cycle pulse
			bitslip_o <= 1'b0;
			if (slip_hold != 3'd0) begin
				slip_hold <= slip_hold - 3'd1;
			end

			case (state)
				SEARCH: begin
					mon_valid <= 1'b0;
					if (is_training) begin
						// Aligned, answer with the lock word
						state       <= LOCKING;
						send_lock_o <= 1'b1;
					end else if (slip_hold == 3'd0) begin
						// Slip once, then wait out the loop
						bitslip_o <= 1'b1;
						slip_hold <= BITSLIP_HOLDOFF - 3'd1;
					end
				end

				LOCKING: begin
					if (!is_training) begin
						// Lost alignment again
						state       <= SEARCH;
						send_lock_o <= 1'b0;
					end else if (rx_word_i == SYNC_LOCK_WORD) begin
						// Far side answered our lock word
						state <= SYNCED;
					end
				end

				SYNCED: begin
					if (mon_valid) begin
						if (rx_word_i[MON_BIT] == mon_expect) begin
							mon_expect <= ~rx_word_i[MON_BIT];
						end else begin
							// Missed toggle, link down
							state       <= SEARCH;
							send_lock_o <= 1'b0;
							mon_valid   <= 1'b0;
						end
					end else if (rx_word_i != SYNC_LOCK_WORD) begin
						// First real data word seeds the monitor
						mon_expect <= ~rx_word_i[MON_BIT];
						mon_valid  <= 1'b1;
					end
				end

				default: begin
					state       <= SEARCH;
					send_lock_o <= 1'b0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Received payload
	//////////////////////////////////////////////////

	// Held at zero until the link is up
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (state == SYNCED) begin
			rx_payload_o <= rx_word_i[MON_BIT-1:0];
		end else begin
			rx_payload_o <= '0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/mux_rx_capture.sv
`timescale 1ns/10ps
`default_nettype none

// Receive word capture with bit slip modelled as a rotation
module mux_rx_capture import mux_link_pkg::*; (
	input  logic      GMII_GTX_CLK_int,
	input  logic      dsp_rst,
	input  mux_word_t raw_word_i,
	input  logic      bitslip_i,
	output mux_word_t rx_word_o
);

	// Accumulated slips
	slip_ofs_t slip_ofs;

	// Rotate left by n, upper half of the doubled word
	function automatic mux_word_t rotl(input mux_word_t w, input slip_ofs_t n);
		logic [15:0] dbl;
		dbl = {w, w} << n;
		return dbl[15:8];
	endfunction

	//////////////////////////////////////////////////
	// Slip offset
	//////////////////////////////////////////////////

	// One step per pulse, wraps modulo 8
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			slip_ofs <= '0;
		end else if (bitslip_i) begin
			slip_ofs <= slip_ofs + 3'd1;
		end
	end

	// Word register, new offset takes effect the cycle after the pulse
	always_ff @(posedge GMII_GTX_CLK_int) begin
		rx_word_o <= rotl(raw_word_i, slip_ofs);
	end

endmodule

`default_nettype wire

// File: verilog/mux_link_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Word types for the board-to-board mux link
//////////////////////////////////////////////////

package mux_link_pkg;

	// One deserialized word, eight bits per divided clock
	typedef logic [7:0] mux_word_t;
	// Switch or LED bits carried below the monitor bit
	typedef logic [6:0] payload_t;
	// Receiver rotation offset, wraps at eight
	typedef logic [2:0] slip_ofs_t;

	//////////////////////////////////////////////////
	// Training and monitor constants
	//////////////////////////////////////////////////

	// Sent while hunting for word alignment
	localparam mux_word_t SYNC_IDLE_WORD = 8'h01;
	// Sent once the far side's training word is seen
	localparam mux_word_t SYNC_LOCK_WORD = 8'h81;
	// Position of the toggling link monitor bit
	localparam int MON_BIT = 7;
	// Slip to next slip spacing, covers trainer -> capture -> trainer
	localparam logic [2:0] BITSLIP_HOLDOFF = 3'd4;

	// Trainer states
	typedef enum logic [1:0] {SEARCH, LOCKING, SYNCED} link_state_t;

endpackage

`default_nettype wire
